// File: bp_pkg.sv
package bp_pkg;

    // instruction address or jump target
    typedef logic [31:0] pc_t;

    // instruction class code coming out of decode
    typedef logic [3:0] ir_type_t;

    // unconditional table index, memory-mode bit plus word address bits
    typedef logic [11:0] ujump_id_t;

    // saturating mispredict counter value
    typedef logic [15:0] miss_count_t;

    // instruction classes
    localparam ir_type_t ir_alu    = 4'd0;
    localparam ir_type_t ir_load   = 4'd1;
    localparam ir_type_t ir_store  = 4'd2;
    localparam ir_type_t ir_branch = 4'd3;
    localparam ir_type_t ir_jal    = 4'd4;
    localparam ir_type_t ir_jalr   = 4'd5;
    localparam ir_type_t ir_lui    = 4'd6;
    localparam ir_type_t ir_auipc  = 4'd7;
    localparam ir_type_t ir_system = 4'd8;

    // default log2 depth of the conditional table
    localparam int COND_INDEX_BITS_DEF = 10;

    // 2-bit saturating branch counter
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } bp_counter_e;

    // pc[28] splits user (1) and machine (0) memory, pc[12:2] picks the word
    function automatic ujump_id_t ujump_id(input pc_t pc);
        return {pc[28], pc[12:2]};
    endfunction

endpackage

// File: bp_resolve.sv
`timescale 1ns/1ps

module bp_resolve import bp_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ex_valid,
    input  ir_type_t    ir_type_ex,
    input  logic        predicted_taken_ex,
    input  logic        taken_ex,
    output logic        ujump_wr,
    output logic        cond_wr,
    output logic        mispredict,
    output miss_count_t miss_count
);

    logic is_jump_ex;
    logic is_branch_ex;
    logic disagree_ex;

    // the only decode of the ex class in the design
    assign is_jump_ex   = (ir_type_ex == ir_jal) || (ir_type_ex == ir_jalr);
    assign is_branch_ex = (ir_type_ex == ir_branch);

    // prediction made in if does not match the resolved outcome
    assign disagree_ex = (predicted_taken_ex != taken_ex);

    // jumps train only when the 1-bit state was wrong
    assign ujump_wr = ex_valid && is_jump_ex && disagree_ex;

    // branches train on every resolve so the counter can move
    assign cond_wr = ex_valid && is_branch_ex;

    // any control transfer that went the wrong way
    assign mispredict = ex_valid && (is_jump_ex || is_branch_ex) && disagree_ex;

    // mispredict counter that sticks at all ones
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_count <= '0;
        end else if (mispredict && (miss_count != '1)) begin
            miss_count <= miss_count + 16'd1;
        end
    end

    // one ex instruction can train only one of the two tables
    a_single_table_wr: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ujump_wr && cond_wr)
    );

endmodule

// File: ujump_predictor.sv
`timescale 1ns/1ps

module ujump_predictor import bp_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    // if side lookup
    input  pc_t  pc_if,
    // ex side training
    input  logic ujump_wr,
    input  pc_t  pc_ex,
    input  logic taken_ex,
    input  pc_t  target_ex,
    // prediction back to if
    output logic ujump_hit,
    output pc_t  ujump_target
);

    // depth fixed by the index format with 2048 entries per memory mode
    localparam int DEPTH = 4096;

    // init bits live in flops so they can be cleared
    logic [DEPTH-1:0] init_q;

    // 1-bit state per entry where 1 means jump
    logic state_mem [DEPTH];

    // jump target per entry
    pc_t target_mem [DEPTH];

    ujump_id_t rd_id;
    ujump_id_t wr_id;
    logic      rd_init;
    logic      rd_state;

    assign rd_id = ujump_id(pc_if);
    assign wr_id = ujump_id(pc_ex);

    // asynchronous read of the if entry
    assign rd_init  = init_q[rd_id];
    assign rd_state = state_mem[rd_id];

    // hit needs a written entry whose state says jump
    // state alone is meaningless until init is set
    assign ujump_hit = rd_init && rd_state;

    // stored target goes out as is and next-pc logic decides whether to use it
    assign ujump_target = target_mem[rd_id];

    // init bit set on the first write to an entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_q <= '0;
        end else if (ujump_wr) begin
            init_q[wr_id] <= 1'b1;
        end
    end

    // state and target are rewritten whole on every training event
    // resolve only strobes this on a wrong prediction
    always_ff @(posedge clk) begin
        if (ujump_wr) begin
            state_mem[wr_id]  <= taken_ex;
            target_mem[wr_id] <= target_ex;
        end
    end

    // an unknown strobe after reset would write x into the table
    a_wr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(ujump_wr)
    );

endmodule

// File: cond_predictor.sv
`timescale 1ns/1ps

module cond_predictor import bp_pkg::*; #(
    parameter int COND_INDEX_BITS = COND_INDEX_BITS_DEF
) (
    input  logic clk,
    input  logic arst_n,
    // if side lookup
    input  pc_t  pc_if,
    // ex side training
    input  logic cond_wr,
    input  pc_t  pc_ex,
    input  logic taken_ex,
    input  pc_t  target_ex,
    // prediction back to if
    output logic cond_taken,
    output pc_t  cond_target
);

    localparam int DEPTH = 1 << COND_INDEX_BITS;

    // entry has been allocated by a branch resolve
    logic [DEPTH-1:0] valid_q;

    // entry has seen a taken resolve so its target is real
    logic [DEPTH-1:0] tgt_valid_q;

    // counter and target payload
    bp_counter_e cnt_mem [DEPTH];
    pc_t         tgt_mem [DEPTH];

    logic [COND_INDEX_BITS-1:0] rd_idx;
    logic [COND_INDEX_BITS-1:0] wr_idx;
    bp_counter_e                rd_cnt;
    bp_counter_e                cnt_next;

    // move one step toward the outcome and stop at the strong ends
    function automatic bp_counter_e step_counter(input bp_counter_e cur, input logic taken);
        bp_counter_e nxt;
        case (cur)
            strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
            weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
            default:          nxt = taken ? strong_taken : weak_taken;
        endcase
        return nxt;
    endfunction

    // word address bits just above the byte offset
    assign rd_idx = pc_if[COND_INDEX_BITS+1:2];
    assign wr_idx = pc_ex[COND_INDEX_BITS+1:2];

    // combinational lookup
    assign rd_cnt = cnt_mem[rd_idx];

    // taken only for a live entry, a taken-side counter and a known target
    assign cond_taken = valid_q[rd_idx] && tgt_valid_q[rd_idx] &&
                        ((rd_cnt == weak_taken) || (rd_cnt == strong_taken));

    assign cond_target = tgt_mem[rd_idx];

    // first write only allocates at weak_not_taken
    // and later writes step from the stored value
    assign cnt_next = valid_q[wr_idx] ? step_counter(cnt_mem[wr_idx], taken_ex)
                                      : weak_not_taken;

    // allocation and target-seen bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q     <= '0;
            tgt_valid_q <= '0;
        end else if (cond_wr) begin
            valid_q[wr_idx] <= 1'b1;
            if (taken_ex) begin
                tgt_valid_q[wr_idx] <= 1'b1;
            end
        end
    end

    // counter moves on every resolve and the target only on a taken one
    always_ff @(posedge clk) begin
        if (cond_wr) begin
            cnt_mem[wr_idx] <= cnt_next;
            if (taken_ex) begin
                tgt_mem[wr_idx] <= target_ex;
            end
        end
    end

endmodule

// File: bp_next_pc.sv
`timescale 1ns/1ps

module bp_next_pc import bp_pkg::*; (
    input  pc_t      pc_if,
    input  ir_type_t ir_type_if,
    // unconditional path
    input  logic     ujump_hit,
    input  pc_t      ujump_target,
    // conditional path
    input  logic     cond_taken,
    input  pc_t      cond_target,
    // fetch redirect
    output logic     predict_taken,
    output pc_t      next_pc
);

    pc_t sel_target;
    pc_t seq_pc;

    // fall-through address
    assign seq_pc = pc_if + 32'd4;

    // pick the predictor that matches the if class
    always_comb begin
        case (ir_type_if)
            ir_jal, ir_jalr: begin
                predict_taken = ujump_hit;
                sel_target    = ujump_target;
            end
            ir_branch: begin
                predict_taken = cond_taken;
                sel_target    = cond_target;
            end
            default: begin
                // not a control transfer, always sequential
                predict_taken = 1'b0;
                sel_target    = seq_pc;
            end
        endcase
    end

    // redirect only when the chosen path says taken
    assign next_pc = predict_taken ? sel_target : seq_pc;

endmodule

// File: bp_top.sv
`timescale 1ns/1ps

module bp_top import bp_pkg::*; #(
    parameter int COND_INDEX_BITS = COND_INDEX_BITS_DEF
) (
    input  logic        clk,
    input  logic        arst_n,
    // if stage
    input  pc_t         pc_if,
    input  ir_type_t    ir_type_if,
    // ex stage
    input  logic        ex_valid,
    input  pc_t         pc_ex,
    input  ir_type_t    ir_type_ex,
    input  pc_t         target_ex,
    input  logic        taken_ex,
    input  logic        predicted_taken_ex,
    // results
    output logic        predict_taken,
    output pc_t         next_pc,
    output logic        mispredict,
    output miss_count_t miss_count
);

    // training strobes from resolve
    logic ujump_wr;
    logic cond_wr;

    // raw predictor outputs
    logic ujump_hit;
    pc_t  ujump_target;
    logic cond_taken;
    pc_t  cond_target;

    // ex side decode and miss counting
    bp_resolve i_bp_resolve (
        .clk                (clk),
        .arst_n             (arst_n),
        .ex_valid           (ex_valid),
        .ir_type_ex         (ir_type_ex),
        .predicted_taken_ex (predicted_taken_ex),
        .taken_ex           (taken_ex),
        .ujump_wr           (ujump_wr),
        .cond_wr            (cond_wr),
        .mispredict         (mispredict),
        .miss_count         (miss_count)
    );

    // jal and jalr table
    ujump_predictor i_ujump_predictor (
        .clk          (clk),
        .arst_n       (arst_n),
        .pc_if        (pc_if),
        .ujump_wr     (ujump_wr),
        .pc_ex        (pc_ex),
        .taken_ex     (taken_ex),
        .target_ex    (target_ex),
        .ujump_hit    (ujump_hit),
        .ujump_target (ujump_target)
    );

    // branch counter table
    cond_predictor #(
        .COND_INDEX_BITS (COND_INDEX_BITS)
    ) i_cond_predictor (
        .clk         (clk),
        .arst_n      (arst_n),
        .pc_if       (pc_if),
        .cond_wr     (cond_wr),
        .pc_ex       (pc_ex),
        .taken_ex    (taken_ex),
        .target_ex   (target_ex),
        .cond_taken  (cond_taken),
        .cond_target (cond_target)
    );

    // if side selection
    bp_next_pc i_bp_next_pc (
        .pc_if         (pc_if),
        .ir_type_if    (ir_type_if),
        .ujump_hit     (ujump_hit),
        .ujump_target  (ujump_target),
        .cond_taken    (cond_taken),
        .cond_target   (cond_target),
        .predict_taken (predict_taken),
        .next_pc       (next_pc)
    );

endmodule

// File: tb_bp_top.sv
`timescale 1ns/1ps

module tb_bp_top import bp_pkg::*; ();

    localparam int  CIB        = 10;
    localparam int  CDEPTH     = 1 << CIB;
    localparam int  N_RANDOM   = 2000;
    localparam int  WAIT_LIMIT = 20;
    localparam pc_t BR_PC      = 32'h0000_0300;
    localparam pc_t BR_TGT     = 32'h0000_0040;

    logic        clk;
    logic        arst_n;
    pc_t         pc_if;
    ir_type_t    ir_type_if;
    logic        ex_valid;
    pc_t         pc_ex;
    ir_type_t    ir_type_ex;
    pc_t         target_ex;
    logic        taken_ex;
    logic        predicted_taken_ex;
    logic        predict_taken;
    pc_t         next_pc;
    logic        mispredict;
    miss_count_t miss_count;

    // reference model of the unconditional table indexed by {pc[28], pc[12:2]}
    logic        m_uinit   [4096];
    logic        m_ustate  [4096];
    pc_t         m_utgt    [4096];
    // conditional table with counter 0..3 from strong not taken to strong taken
    logic        m_cvalid  [CDEPTH];
    logic        m_ctvalid [CDEPTH];
    int          m_ccnt    [CDEPTH];
    pc_t         m_ctgt    [CDEPTH];
    miss_count_t m_miss;

    logic [31:0] rng;
    int          n_driven;
    int          n_checked;

    bp_top #(
        .COND_INDEX_BITS (CIB)
    ) i_bp_top (
        .clk                (clk),
        .arst_n             (arst_n),
        .pc_if              (pc_if),
        .ir_type_if         (ir_type_if),
        .ex_valid           (ex_valid),
        .pc_ex              (pc_ex),
        .ir_type_ex         (ir_type_ex),
        .target_ex          (target_ex),
        .taken_ex           (taken_ex),
        .predicted_taken_ex (predicted_taken_ex),
        .predict_taken      (predict_taken),
        .next_pc            (next_pc),
        .mispredict         (mispredict),
        .miss_count         (miss_count)
    );

    // 100 ns period
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one of 16 words at 0x400 in either memory mode
    function automatic pc_t rand_pc(input logic [31:0] r);
        pc_t p;
        p     = 32'h0000_0400 | {26'd0, r[5:2], 2'b00};
        p[28] = r[20];
        return p;
    endfunction

    // weighted toward control transfers
    function automatic ir_type_t rand_type(input logic [7:0] r);
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return ir_branch;
            3'd3:             return ir_jal;
            3'd4:             return ir_jalr;
            3'd5:             return ir_alu;
            3'd6:             return ir_load;
            default:          return ir_system;
        endcase
    endfunction

    // expected {predict_taken, next_pc} for an if lookup
    function automatic logic [32:0] ref_predict(input pc_t pc, input ir_type_t ty);
        logic [11:0] uid;
        int          cid;
        logic        tk;
        pc_t         tgt;
        uid = {pc[28], pc[12:2]};
        cid = int'(pc[CIB+1:2]);
        tk  = 1'b0;
        tgt = pc + 32'd4;
        if ((ty == ir_jal) || (ty == ir_jalr)) begin
            if (m_uinit[uid] && m_ustate[uid]) begin
                tk  = 1'b1;
                tgt = m_utgt[uid];
            end
        end else if (ty == ir_branch) begin
            // taken half of the counter and a target seen at least once
            if (m_cvalid[cid] && m_ctvalid[cid] && (m_ccnt[cid] >= 2)) begin
                tk  = 1'b1;
                tgt = m_ctgt[cid];
            end
        end
        return {tk, tgt};
    endfunction

    task automatic model_clear();
        int k;
        for (k = 0; k < 4096; k++) begin
            m_uinit[k]  = 1'b0;
            m_ustate[k] = 1'b0;
            m_utgt[k]   = '0;
        end
        for (k = 0; k < CDEPTH; k++) begin
            m_cvalid[k]  = 1'b0;
            m_ctvalid[k] = 1'b0;
            m_ccnt[k]    = 0;
            m_ctgt[k]    = '0;
        end
        m_miss = '0;
    endtask

    // apply the ex inputs seen at a rising edge
    task automatic model_update();
        logic [11:0] uid;
        int          cid;
        logic        jump;
        logic        wrong;
        uid   = {pc_ex[28], pc_ex[12:2]};
        cid   = int'(pc_ex[CIB+1:2]);
        jump  = (ir_type_ex == ir_jal) || (ir_type_ex == ir_jalr);
        wrong = (predicted_taken_ex != taken_ex);
        if (ex_valid && (jump || (ir_type_ex == ir_branch)) && wrong && (m_miss != '1)) begin
            m_miss = m_miss + 16'd1;
        end
        // jumps learn only from a wrong guess
        if (ex_valid && jump && wrong) begin
            m_uinit[uid]  = 1'b1;
            m_ustate[uid] = taken_ex;
            m_utgt[uid]   = target_ex;
        end
        if (ex_valid && (ir_type_ex == ir_branch)) begin
            // first resolve only allocates at weak not taken
            if (!m_cvalid[cid]) begin
                m_ccnt[cid] = 1;
            end else if (taken_ex) begin
                m_ccnt[cid] = (m_ccnt[cid] == 3) ? 3 : m_ccnt[cid] + 1;
            end else begin
                m_ccnt[cid] = (m_ccnt[cid] == 0) ? 0 : m_ccnt[cid] - 1;
            end
            m_cvalid[cid] = 1'b1;
            if (taken_ex) begin
                m_ctvalid[cid] = 1'b1;
                m_ctgt[cid]    = target_ex;
            end
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_count(input miss_count_t got, input miss_count_t exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "wait limit reached");
    endtask

    // step to the next drive point with the ex side idle unless set again
    task automatic advance();
        @(posedge clk);
        #10;
        ex_valid = 1'b0;
        n_driven++;
    endtask

    task automatic set_if(input pc_t pc, input ir_type_t ty);
        pc_if      = pc;
        ir_type_if = ty;
    endtask

    task automatic set_ex(input pc_t pc, input ir_type_t ty, input pc_t tgt,
                          input logic tk, input logic pred);
        ex_valid           = 1'b1;
        pc_ex              = pc;
        ir_type_ex         = ty;
        target_ex          = tgt;
        taken_ex           = tk;
        predicted_taken_ex = pred;
    endtask

    // directed lookup result checked well ahead of the next edge
    task automatic expect_if(input logic tk, input pc_t npc, input string what);
        #20;
        check_bit(predict_taken, tk, what);
        check_pc(next_pc, npc, what);
    endtask

    task automatic branch_step(input logic tk, input logic exp_tk);
        advance();
        set_if(BR_PC, ir_branch);
        set_ex(BR_PC, ir_branch, BR_TGT, tk, exp_tk);
        expect_if(exp_tk, exp_tk ? BR_TGT : BR_PC + 32'd4, "branch counter lookup");
    endtask

    // checks outputs mid-cycle and then follows the edge in the model
    initial begin : compare_outputs
        logic [32:0] exp_if;
        logic        exp_miss;
        int          waited;
        waited = 0;
        while ((arst_n !== 1'b1) && (waited < WAIT_LIMIT)) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) begin
            report_timeout("reset release");
        end
        forever begin
            @(negedge clk);
            exp_if   = ref_predict(pc_if, ir_type_if);
            exp_miss = ex_valid && (ir_type_ex inside {ir_branch, ir_jal, ir_jalr}) &&
                       (predicted_taken_ex != taken_ex);
            check_bit(predict_taken, exp_if[32], "predict_taken");
            check_pc(next_pc, exp_if[31:0], "next_pc");
            check_bit(mispredict, exp_miss, "mispredict");
            @(posedge clk);
            model_update();
            #1;
            check_count(miss_count, m_miss, "miss_count");
            n_checked++;
        end
    end

    initial begin : stimulus
        pc_t         pc;
        logic [31:0] r_ex;
        int          i;
        int          waited;
        clk                = 1'b0;
        arst_n             = 1'b0;
        pc_if              = '0;
        ir_type_if         = ir_alu;
        ex_valid           = 1'b0;
        pc_ex              = '0;
        ir_type_ex         = ir_alu;
        target_ex          = '0;
        taken_ex           = 1'b0;
        predicted_taken_ex = 1'b0;
        rng                = 32'd84534;
        n_driven           = 0;
        n_checked          = 0;
        model_clear();
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // empty tables never redirect for any class
        for (i = 0; i < 9; i++) begin
            advance();
            pc = 32'h1000_0800 + 32'(i) * 32'd68;
            set_if(pc, ir_type_t'(i));
            expect_if(1'b0, pc + 32'd4, "lookup after reset");
            check_count(miss_count, '0, "miss_count after reset");
        end

        // jal guessed not taken but resolved taken
        advance();
        set_ex(32'h0000_0100, ir_jal, 32'h0000_2000, 1'b1, 1'b0);
        #20;
        check_bit(mispredict, 1'b1, "jal mispredict");
        advance();
        set_if(32'h0000_0100, ir_jal);
        expect_if(1'b1, 32'h0000_2000, "trained jal");
        advance();
        set_if(32'h0000_0100, ir_load);
        expect_if(1'b0, 32'h0000_0104, "load at jal pc");

        // pc[28] picks a separate entry
        advance();
        set_ex(32'h1000_0200, ir_jalr, 32'h0000_3000, 1'b1, 1'b0);
        advance();
        set_if(32'h0000_0200, ir_jalr);
        expect_if(1'b0, 32'h0000_0204, "jalr in other memory mode");
        advance();
        set_if(32'h1000_0200, ir_jalr);
        expect_if(1'b1, 32'h0000_3000, "trained jalr");

        // allocate, step up to strong taken, then two steps back down
        branch_step(1'b1, 1'b0);
        branch_step(1'b1, 1'b0);
        branch_step(1'b1, 1'b1);
        branch_step(1'b1, 1'b1);
        branch_step(1'b0, 1'b1);
        branch_step(1'b0, 1'b1);
        branch_step(1'b0, 1'b0);

        // random mix checked by the compare process alone
        for (i = 0; i < N_RANDOM; i++) begin
            advance();
            rng = xorshift32(rng);
            set_if(rand_pc(rng), rand_type(rng[31:24]));
            rng  = xorshift32(rng);
            r_ex = rng;
            rng  = xorshift32(rng);
            if (r_ex[1:0] != 2'b00) begin
                set_ex(rand_pc(r_ex), rand_type(r_ex[31:24]), {rng[31:2], 2'b00},
                       r_ex[6], r_ex[7]);
            end
        end

        advance();
        waited = 0;
        while ((n_checked < n_driven) && (waited < WAIT_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
        if (n_checked < n_driven) begin
            report_timeout("the compare process to drain");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: bp_top.f
bp_pkg.sv
bp_resolve.sv
ujump_predictor.sv
cond_predictor.sv
bp_next_pc.sv
bp_top.sv
tb_bp_top.sv

// File: Makefile
# verilator build and run for the branch predictor testbench

TOP      ?= tb_bp_top
FILELIST ?= bp_top.f
LOG      ?= sim.log
OBJDIR   ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
